/* rtl/cpu_pkg.sv */
/*
 * Shared widths, opcode and funct codes, ALU operation type and the instruction
 * word layout for the multi-cycle processor. Modules import it in their bodies.
 */
package cpu_pkg;

    // Word and storage sizes
    localparam int XLEN          = 32;
    localparam int MEM_DEPTH     = 256;
    localparam int MEM_ADDR_W    = 8;
    localparam int REG_COUNT     = 32;
    localparam int REG_ADDR_W    = 5;
    // The loader fills data memory downward from the top word
    localparam int DATA_LOAD_TOP = 255;

    typedef logic [XLEN-1:0]       word_t;
    typedef logic [MEM_ADDR_W-1:0] mem_addr_t;
    typedef logic [REG_ADDR_W-1:0] reg_addr_t;

    // Opcodes, bits 31:26 of every instruction
    localparam logic [5:0] OP_RTYPE = 6'd0;
    localparam logic [5:0] OP_ADDI  = 6'd1;
    localparam logic [5:0] OP_AND   = 6'd3;
    localparam logic [5:0] OP_OR    = 6'd4;
    localparam logic [5:0] OP_ANDI  = 6'd5;
    localparam logic [5:0] OP_ORI   = 6'd6;
    // Shifts are R-format: rd gets rs shifted by the shamt field, funct picks the direction
    localparam logic [5:0] OP_SHIFT = 6'd7;
    localparam logic [5:0] OP_LW    = 6'd8;
    localparam logic [5:0] OP_SW    = 6'd9;
    localparam logic [5:0] OP_BEQ   = 6'd10;
    localparam logic [5:0] OP_BNE   = 6'd11;
    localparam logic [5:0] OP_J     = 6'd16;
    localparam logic [5:0] OP_SLT   = 6'd19;
    localparam logic [5:0] OP_SLTI  = 6'd20;

    // Funct codes shared by OP_RTYPE (add, sub) and OP_SHIFT (sll, srl)
    localparam logic [5:0] FN_ADD_SLL = 6'd0;
    localparam logic [5:0] FN_SUB_SRL = 6'd1;

    typedef enum logic [2:0] {
        ALU_ADD,
        ALU_SUB,
        ALU_AND,
        ALU_OR,
        ALU_SLL,
        ALU_SRL,
        ALU_SLT
    } alu_op_t;

    // Register format: opcode rs rt rd shamt funct
    typedef struct packed {
        logic [5:0] opcode;
        reg_addr_t  rs;
        reg_addr_t  rt;
        reg_addr_t  rd;
        logic [4:0] shamt;
        logic [5:0] funct;
    } r_fmt_t;

    // Immediate format, rt is the destination for ALU and load forms
    typedef struct packed {
        logic [5:0]  opcode;
        reg_addr_t   rs;
        reg_addr_t   rt;
        logic [15:0] imm;
    } i_fmt_t;

    typedef struct packed {
        logic [5:0]  opcode;
        logic [25:0] target;
    } j_fmt_t;

    // The same instruction word seen through all three formats
    typedef union packed {
        r_fmt_t r;
        i_fmt_t i;
        j_fmt_t j;
    } instr_u;

endpackage

/* rtl/mem_if.sv */
/*
 * Data-memory port between the controller and the data memory.
 * rdata is registered and follows addr by one cycle.
 */
`timescale 1ns/1ns

interface mem_if;
    import cpu_pkg::*;

    mem_addr_t addr;
    word_t     wdata;
    logic      we;
    word_t     rdata;

    modport controller (output addr, output wdata, output we, input rdata);

    modport memory (input addr, input wdata, input we, output rdata);

endinterface

/* rtl/regfile_if.sv */
/*
 * Register-file port with two combinational reads and one clocked write.
 */
`timescale 1ns/1ns

interface regfile_if;
    import cpu_pkg::*;

    reg_addr_t ra1;
    reg_addr_t ra2;
    reg_addr_t wa;
    word_t     rd1;
    word_t     rd2;
    word_t     wd;
    logic      we;

    modport controller (output ra1, ra2, wa, wd, we, input rd1, rd2);

    modport register (input ra1, ra2, wa, wd, we, output rd1, rd2);

endinterface

/* rtl/instr_mem.sv */
/*
 * Instruction memory. The loader writes it while the program is fed in,
 * and the fetch address is read into an output register every cycle.
 */
`timescale 1ns/1ns

module instr_mem (
    input  logic              clk,
    input  logic              we,
    input  cpu_pkg::mem_addr_t waddr,
    input  cpu_pkg::mem_addr_t raddr,
    input  cpu_pkg::word_t     wdata,
    output cpu_pkg::word_t     rdata
);
    import cpu_pkg::*;

    word_t mem [MEM_DEPTH];

    // Writes only happen during loading, so a read never races a write in practice
    always_ff @(posedge clk) begin
        if (we) begin
            mem[waddr] <= wdata;
        end
        // The word read at the FETCH edge is valid during DECODE
        rdata <= mem[raddr];
    end

endmodule

/* rtl/data_mem.sv */
/*
 * Data memory. The controller port has a synchronous write and a registered
 * read; the peek port reads any word combinationally for observation.
 */
`timescale 1ns/1ns

module data_mem (
    input  logic               clk,
    mem_if.memory              bus,
    input  cpu_pkg::mem_addr_t peek_addr,
    output cpu_pkg::word_t     peek_data
);
    import cpu_pkg::*;

    word_t mem [MEM_DEPTH];

    always_ff @(posedge clk) begin
        // Both the loader and sw come through this port
        if (bus.we) begin
            mem[bus.addr] <= bus.wdata;
        end
        // lw presents its address in EXECUTE and picks the word up in MEM
        bus.rdata <= mem[bus.addr];
    end

    // A word written at one edge shows here right after that edge
    assign peek_data = mem[peek_addr];

endmodule

/* rtl/reg_file.sv */
/*
 * General-purpose register file, 32 words. Register 0 is never written
 * and always reads as zero on both read ports.
 */
`timescale 1ns/1ns

module reg_file (
    input  logic        clk,
    input  logic        rst_n,
    regfile_if.register rf
);
    import cpu_pkg::*;

    word_t regs [REG_COUNT];

    // All registers start from zero so programs see a known state
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            for (int i = 0; i < REG_COUNT; i++) begin
                regs[i] <= '0;
            end
        end else if (rf.we && (rf.wa != '0)) begin
            // A write aimed at register 0 is simply dropped
            regs[rf.wa] <= rf.wd;
        end
    end

    // Reads are combinational so EXECUTE sees operands in the same cycle
    assign rf.rd1 = (rf.ra1 == '0) ? '0 : regs[rf.ra1];
    assign rf.rd2 = (rf.ra2 == '0) ? '0 : regs[rf.ra2];

    // Register 0 must read zero whatever the controller wrote earlier
    a_reg0_zero : assert property (
        @(posedge clk) disable iff (!rst_n)
        ((rf.ra1 != '0) || (rf.rd1 == '0)) && ((rf.ra2 != '0) || (rf.rd2 == '0))
    );

endmodule

/* rtl/alu.sv */
/*
 * Combinational ALU for add, sub, logic, shifts and signed compare.
 * zero is used by the controller to resolve beq and bne from a subtract.
 */
`timescale 1ns/1ns

module alu (
    input  cpu_pkg::alu_op_t op,
    input  cpu_pkg::word_t   a,
    input  cpu_pkg::word_t   b,
    output cpu_pkg::word_t   result,
    output logic             zero
);
    import cpu_pkg::*;

    // Shift distance only ever needs the low five bits
    logic [4:0] shift_amt;
    logic       a_lt_b;

    assign shift_amt = b[4:0];

    // Signed order for slt and slti
    assign a_lt_b = $signed(a) < $signed(b);

    always_comb begin
        case (op)
            ALU_ADD: begin
                result = a + b;
            end
            ALU_SUB: begin
                result = a - b;
            end
            ALU_AND: begin
                result = a & b;
            end
            ALU_OR: begin
                result = a | b;
            end
            ALU_SLL: begin
                result = a << shift_amt;
            end
            // Logical right shift, zeros come in from the top
            ALU_SRL: begin
                result = a >> shift_amt;
            end
            ALU_SLT: begin
                result = {{(XLEN-1){1'b0}}, a_lt_b};
            end
            default: begin
                result = '0;
            end
        endcase
    end

    assign zero = (result == '0);

endmodule

/* rtl/cpu_control.sv */
/*
 * Controller that takes the loader words, then steps each instruction through
 * FETCH, DECODE, EXECUTE (and MEM for lw) until the PC hits the instruction count.
 */
`timescale 1ns/1ns

module cpu_control (
    input  logic               clk,
    input  logic               rst_n,
    input  logic               start_signal,
    input  logic               load_valid,
    input  logic               add_into,
    input  cpu_pkg::word_t     new_word,
    output logic               end_signal,
    output logic               imem_we,
    output cpu_pkg::mem_addr_t imem_waddr,
    output cpu_pkg::mem_addr_t imem_raddr,
    input  cpu_pkg::word_t     imem_rdata,
    mem_if.controller          dmem,
    regfile_if.controller      rf,
    output cpu_pkg::alu_op_t   alu_op,
    output cpu_pkg::word_t     alu_a,
    output cpu_pkg::word_t     alu_b,
    input  cpu_pkg::word_t     alu_result,
    input  logic               alu_zero
);
    import cpu_pkg::*;

    typedef enum logic [2:0] {
        S_LOAD,
        S_FETCH,
        S_DECODE,
        S_EXECUTE,
        S_MEM,
        S_DONE
    } state_t;

    state_t    state;
    mem_addr_t pc;
    mem_addr_t next_pc;
    mem_addr_t pc_plus1;
    // Next free instruction slot, which is also the number of loaded instructions
    mem_addr_t instr_count;
    mem_addr_t data_ptr;
    instr_u    ir;
    word_t     imm_sext;
    word_t     imm_zext;
    logic      load_strobe;
    logic      is_lw;
    logic      is_sw;
    logic      wb_en;
    logic      wb_rd;

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            state       <= S_LOAD;
            pc          <= '0;
            instr_count <= '0;
            data_ptr    <= mem_addr_t'(DATA_LOAD_TOP);
        end else begin
            case (state)
                S_LOAD: begin
                    // The first edge that sees start closes loading for good
                    if (start_signal) begin
                        state <= S_FETCH;
                    end else if (load_valid) begin
                        if (add_into) begin
                            data_ptr <= data_ptr - 1'b1;
                        end else begin
                            instr_count <= instr_count + 1'b1;
                        end
                    end
                end
                S_FETCH: begin
                    state <= (pc == instr_count) ? S_DONE : S_DECODE;
                end
                S_DECODE: begin
                    state <= S_EXECUTE;
                end
                S_EXECUTE: begin
                    pc    <= next_pc;
                    state <= is_lw ? S_MEM : S_FETCH;
                end
                S_MEM: begin
                    state <= S_FETCH;
                end
                S_DONE: begin
                    state <= S_DONE;
                end
                default: begin
                    state <= S_LOAD;
                end
            endcase
        end
    end

    // The fetched word arrives during DECODE and is held for EXECUTE and MEM
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            ir <= '0;
        end else if (state == S_DECODE) begin
            ir <= imem_rdata;
        end
    end

    assign end_signal  = (state == S_DONE);
    assign load_strobe = (state == S_LOAD) && load_valid && !start_signal;
    assign imem_we     = load_strobe && !add_into;
    assign imem_waddr  = instr_count;
    assign imem_raddr  = pc;

    assign imm_sext = {{(XLEN-16){ir.i.imm[15]}}, ir.i.imm};
    assign imm_zext = {{(XLEN-16){1'b0}}, ir.i.imm};
    assign is_lw    = (ir.i.opcode == OP_LW);
    assign is_sw    = (ir.i.opcode == OP_SW);

    // Opcode decode into ALU operation, second operand and write-back choice
    always_comb begin
        alu_op = ALU_ADD;
        alu_b  = rf.rd2;
        wb_en  = 1'b0;
        wb_rd  = 1'b0;
        case (ir.r.opcode)
            OP_RTYPE: begin
                wb_rd = 1'b1;
                wb_en = (ir.r.funct == FN_ADD_SLL) || (ir.r.funct == FN_SUB_SRL);
                if (ir.r.funct == FN_SUB_SRL) begin
                    alu_op = ALU_SUB;
                end
            end
            OP_ADDI: begin
                alu_b = imm_sext;
                wb_en = 1'b1;
            end
            OP_AND: begin
                alu_op = ALU_AND;
                wb_en  = 1'b1;
                wb_rd  = 1'b1;
            end
            OP_OR: begin
                alu_op = ALU_OR;
                wb_en  = 1'b1;
                wb_rd  = 1'b1;
            end
            OP_ANDI: begin
                alu_op = ALU_AND;
                alu_b  = imm_zext;
                wb_en  = 1'b1;
            end
            OP_ORI: begin
                alu_op = ALU_OR;
                alu_b  = imm_zext;
                wb_en  = 1'b1;
            end
            OP_SHIFT: begin
                alu_op = (ir.r.funct == FN_SUB_SRL) ? ALU_SRL : ALU_SLL;
                alu_b  = {{(XLEN-5){1'b0}}, ir.r.shamt};
                wb_en  = (ir.r.funct == FN_ADD_SLL) || (ir.r.funct == FN_SUB_SRL);
                wb_rd  = 1'b1;
            end
            // Address is rs plus the signed offset; lw writes back in MEM
            OP_LW, OP_SW: begin
                alu_b = imm_sext;
            end
            OP_BEQ, OP_BNE: begin
                alu_op = ALU_SUB;
            end
            OP_SLT: begin
                alu_op = ALU_SLT;
                wb_en  = (ir.r.funct == FN_ADD_SLL);
                wb_rd  = 1'b1;
            end
            OP_SLTI: begin
                alu_op = ALU_SLT;
                alu_b  = imm_sext;
                wb_en  = 1'b1;
            end
            default: begin
                // Unknown opcodes fall through as a no-op
                wb_en = 1'b0;
            end
        endcase
    end

    assign alu_a    = rf.rd1;
    assign pc_plus1 = pc + 1'b1;

    // Branch offsets are relative to the following instruction
    always_comb begin
        case (ir.i.opcode)
            OP_BEQ: begin
                next_pc = alu_zero ? pc_plus1 + imm_sext[MEM_ADDR_W-1:0] : pc_plus1;
            end
            OP_BNE: begin
                next_pc = alu_zero ? pc_plus1 : pc_plus1 + imm_sext[MEM_ADDR_W-1:0];
            end
            OP_J: begin
                next_pc = ir.j.target[MEM_ADDR_W-1:0];
            end
            default: begin
                next_pc = pc_plus1;
            end
        endcase
    end

    assign rf.ra1 = ir.r.rs;
    assign rf.ra2 = ir.r.rt;
    assign rf.wa  = wb_rd ? ir.r.rd : ir.i.rt;
    assign rf.wd  = (state == S_MEM) ? dmem.rdata : alu_result;
    assign rf.we  = ((state == S_EXECUTE) && wb_en) || (state == S_MEM);

    // The loader owns the data port until start, then lw and sw use it
    assign dmem.addr  = (state == S_LOAD) ? data_ptr : alu_result[MEM_ADDR_W-1:0];
    assign dmem.wdata = (state == S_LOAD) ? new_word : rf.rd2;
    assign dmem.we    = (load_strobe && add_into) || ((state == S_EXECUTE) && is_sw);

    // Once the program has finished it stays finished until reset
    a_end_sticky : assert property (
        @(posedge clk) disable iff (!rst_n)
        end_signal |=> end_signal
    );

    // Data memory is only written by the loader or by a store in EXECUTE
    a_dmem_we_src : assert property (
        @(posedge clk) disable iff (!rst_n)
        dmem.we |-> (((state == S_LOAD) && add_into)
                     || ((state == S_EXECUTE) && (ir.i.opcode == OP_SW)))
    );

endmodule

/* rtl/cpu_top.sv */
/*
 * Processor top level. Connects the memories, register file, ALU and controller
 * and exposes the load port, start/end handshake and a data-memory peek port.
 */
`timescale 1ns/1ns

module cpu_top (
    input  logic               clk,
    input  logic               rst_n,
    input  logic               start_signal,
    input  logic               load_valid,
    input  logic               add_into,
    input  cpu_pkg::word_t     new_word,
    input  cpu_pkg::mem_addr_t peek_addr,
    output logic               end_signal,
    output cpu_pkg::word_t     peek_data
);
    import cpu_pkg::*;

    logic      imem_we;
    mem_addr_t imem_waddr;
    mem_addr_t imem_raddr;
    word_t     imem_rdata;
    alu_op_t   alu_op;
    word_t     alu_a;
    word_t     alu_b;
    word_t     alu_result;
    logic      alu_zero;

    mem_if     dmem_bus ();
    regfile_if rf_bus ();

    instr_mem i_instr_mem (
        .clk   (clk),
        .we    (imem_we),
        .waddr (imem_waddr),
        .raddr (imem_raddr),
        .wdata (new_word),
        .rdata (imem_rdata)
    );

    data_mem i_data_mem (
        .clk       (clk),
        .bus       (dmem_bus.memory),
        .peek_addr (peek_addr),
        .peek_data (peek_data)
    );

    reg_file i_reg_file (
        .clk   (clk),
        .rst_n (rst_n),
        .rf    (rf_bus.register)
    );

    alu i_alu (
        .op     (alu_op),
        .a      (alu_a),
        .b      (alu_b),
        .result (alu_result),
        .zero   (alu_zero)
    );

    cpu_control i_cpu_control (
        .clk          (clk),
        .rst_n        (rst_n),
        .start_signal (start_signal),
        .load_valid   (load_valid),
        .add_into     (add_into),
        .new_word     (new_word),
        .end_signal   (end_signal),
        .imem_we      (imem_we),
        .imem_waddr   (imem_waddr),
        .imem_raddr   (imem_raddr),
        .imem_rdata   (imem_rdata),
        .dmem         (dmem_bus.controller),
        .rf           (rf_bus.controller),
        .alu_op       (alu_op),
        .alu_a        (alu_a),
        .alu_b        (alu_b),
        .alu_result   (alu_result),
        .alu_zero     (alu_zero)
    );

endmodule

/* verif/cpu_tests.svh */
/*
 * Instruction encoders and directed tests, included inside the testbench module.
 * Field layouts follow the R, I and J formats of the processor.
 */

function automatic word_t enc_rtype(input logic [5:0] op, input int rd, input int rs,
                                    input int rt, input logic [5:0] funct);
    return {op, reg_addr_t'(rs), reg_addr_t'(rt), reg_addr_t'(rd), 5'd0, funct};
endfunction

// Shifts take rs and put the result in rd with the distance in the shamt field
function automatic word_t enc_shift(input int rd, input int rs, input int shamt,
                                    input logic [5:0] funct);
    return {OP_SHIFT, reg_addr_t'(rs), 5'd0, reg_addr_t'(rd), 5'(shamt), funct};
endfunction

function automatic word_t enc_itype(input logic [5:0] op, input int rt, input int rs,
                                    input int imm);
    return {op, reg_addr_t'(rs), reg_addr_t'(rt), 16'(imm)};
endfunction

function automatic word_t enc_jump(input int target);
    return {OP_J, 26'(target)};
endfunction

// When the signs differ the negative operand is the smaller one
function automatic word_t signed_less(input word_t x, input word_t y);
    if (x[31] != y[31]) begin
        return word_t'(x[31]);
    end
    // Equal signs order the same way as plain unsigned numbers
    return (x < y) ? 32'd1 : 32'd0;
endfunction

function automatic void emit(input word_t instr);
    prog_q.push_back(instr);
endfunction

task automatic test_load_and_peek();
    word_t words[5];
    begin_test();
    words = '{32'hDEAD_BEEF, 32'h0000_0001, 32'h8000_0000, 32'h1234_5678, 32'hFFFF_FFFF};
    foreach (words[i]) data_q.push_back(words[i]);
    load_queues();
    // Data fills downward from the top word
    for (int i = 0; i < 5; i++) check_mem(255 - i, words[i]);
    // Nothing has run yet, so the end flag is still low
    check("end_signal", 32'd0, word_t'(end_signal));
    // With no instructions the first FETCH already ends the run
    run_program();
    check("end_signal", 32'd1, word_t'(end_signal));
    end_test("load_and_peek");
endtask

task automatic test_alu_ops();
    word_t a;
    word_t b;
    word_t expected[10];
    begin_test();
    a = 32'd1234;
    b = -32'sd100;
    emit(enc_itype(OP_ADDI, 1, 0, 1234));
    emit(enc_itype(OP_ADDI, 2, 0, -100));
    emit(enc_rtype(OP_RTYPE, 3, 1, 2, FN_ADD_SLL));
    emit(enc_rtype(OP_RTYPE, 4, 1, 2, FN_SUB_SRL));
    emit(enc_rtype(OP_AND, 5, 1, 2, 6'd0));
    emit(enc_rtype(OP_OR, 6, 1, 2, 6'd0));
    emit(enc_itype(OP_ANDI, 7, 2, 'hF0F0));
    emit(enc_itype(OP_ORI, 8, 1, 'h8000));
    emit(enc_shift(9, 1, 4, FN_ADD_SLL));
    emit(enc_shift(10, 2, 8, FN_SUB_SRL));
    // Registers 1 to 10 land at addresses 0 to 9
    for (int r = 1; r <= 10; r++) emit(enc_itype(OP_SW, r, 0, r - 1));
    // andi and ori take a zero-extended immediate
    expected = '{a, b, a + b, a - b, a & b, a | b,
                 b & 32'h0000_F0F0, a | 32'h0000_8000, a << 4, b >> 8};
    load_queues();
    run_program();
    for (int i = 0; i < 10; i++) check_mem(i, expected[i]);
    end_test("alu_ops");
endtask

task automatic test_load_store_zero();
    word_t d0;
    word_t d1;
    begin_test();
    d0 = 32'h1234_5678;
    d1 = 32'h0FED_CBA9;
    data_q.push_back(d0);
    data_q.push_back(d1);
    // An offset of -1 from register 0 wraps to the top word
    emit(enc_itype(OP_LW, 1, 0, -1));
    emit(enc_itype(OP_LW, 2, 0, 254));
    emit(enc_rtype(OP_RTYPE, 3, 1, 2, FN_ADD_SLL));
    emit(enc_itype(OP_SW, 3, 0, 20));
    emit(enc_itype(OP_SW, 3, 0, 21));
    emit(enc_itype(OP_ADDI, 0, 0, 77));
    emit(enc_itype(OP_SW, 0, 0, 21));
    emit(enc_rtype(OP_RTYPE, 4, 0, 1, FN_ADD_SLL));
    emit(enc_itype(OP_SW, 4, 0, 22));
    emit(enc_itype(OP_SW, 2, 0, 23));
    load_queues();
    run_program();
    check_mem(20, d0 + d1);
    check_mem(21, 32'd0);
    check_mem(22, d0);
    check_mem(23, d1);
    end_test("load_store_zero");
endtask

task automatic test_branch_jump();
    word_t sum;
    begin_test();
    sum = '0;
    for (int n = 5; n > 0; n--) sum += word_t'(n);
    emit(enc_itype(OP_ADDI, 1, 0, 5));
    emit(enc_itype(OP_ADDI, 2, 0, 0));
    emit(enc_rtype(OP_RTYPE, 2, 2, 1, FN_ADD_SLL));
    emit(enc_itype(OP_ADDI, 1, 1, -1));
    // Back to the add at address 2 while the counter is not zero
    emit(enc_itype(OP_BNE, 0, 1, -3));
    emit(enc_itype(OP_ADDI, 3, 0, 11));
    emit(enc_itype(OP_BEQ, 3, 3, 1));
    emit(enc_itype(OP_ADDI, 3, 0, 99));
    emit(enc_jump(10));
    emit(enc_itype(OP_ADDI, 2, 0, 99));
    // Not taken because register 1 holds 0 and register 3 holds 11
    emit(enc_itype(OP_BEQ, 3, 1, 1));
    emit(enc_itype(OP_ADDI, 4, 0, 7));
    emit(enc_itype(OP_SW, 2, 0, 40));
    emit(enc_itype(OP_SW, 3, 0, 41));
    emit(enc_itype(OP_SW, 1, 0, 42));
    emit(enc_itype(OP_SW, 4, 0, 43));
    load_queues();
    run_program();
    check_mem(40, sum);
    check_mem(41, 32'd11);
    check_mem(42, 32'd0);
    check_mem(43, 32'd7);
    end_test("branch_jump");
endtask

task automatic test_signed_compare();
    word_t neg;
    word_t pos;
    begin_test();
    neg = -32'sd5;
    pos = 32'd3;
    emit(enc_itype(OP_ADDI, 1, 0, -5));
    emit(enc_itype(OP_ADDI, 2, 0, 3));
    emit(enc_rtype(OP_SLT, 3, 1, 2, FN_ADD_SLL));
    emit(enc_rtype(OP_SLT, 4, 2, 1, FN_ADD_SLL));
    emit(enc_itype(OP_SLTI, 5, 1, -6));
    emit(enc_itype(OP_SLTI, 6, 1, -4));
    emit(enc_itype(OP_SLTI, 7, 2, -1));
    emit(enc_rtype(OP_SLT, 8, 1, 1, FN_ADD_SLL));
    for (int r = 3; r <= 8; r++) emit(enc_itype(OP_SW, r, 0, 57 + r));
    load_queues();
    run_program();
    check_mem(60, signed_less(neg, pos));
    check_mem(61, signed_less(pos, neg));
    check_mem(62, signed_less(neg, -32'sd6));
    check_mem(63, signed_less(neg, -32'sd4));
    check_mem(64, signed_less(pos, -32'sd1));
    check_mem(65, signed_less(neg, neg));
    end_test("signed_compare");
endtask

task automatic test_random_operands();
    word_t a[8];
    word_t b[8];
    int    base;
    begin_test();
    for (int k = 0; k < 8; k++) begin
        a[k] = $random(seed);
        b[k] = $random(seed);
        data_q.push_back(a[k]);
        data_q.push_back(b[k]);
    end
    // Pair k sits at 255-2k and 254-2k and its five results go from 100+5k up
    for (int k = 0; k < 8; k++) begin
        base = 100 + 5 * k;
        emit(enc_itype(OP_LW, 1, 0, 255 - 2 * k));
        emit(enc_itype(OP_LW, 2, 0, 254 - 2 * k));
        emit(enc_rtype(OP_RTYPE, 3, 1, 2, FN_ADD_SLL));
        emit(enc_itype(OP_SW, 3, 0, base));
        emit(enc_rtype(OP_RTYPE, 4, 1, 2, FN_SUB_SRL));
        emit(enc_itype(OP_SW, 4, 0, base + 1));
        emit(enc_rtype(OP_AND, 5, 1, 2, 6'd0));
        emit(enc_itype(OP_SW, 5, 0, base + 2));
        emit(enc_rtype(OP_OR, 6, 1, 2, 6'd0));
        emit(enc_itype(OP_SW, 6, 0, base + 3));
        emit(enc_rtype(OP_SLT, 7, 1, 2, FN_ADD_SLL));
        emit(enc_itype(OP_SW, 7, 0, base + 4));
    end
    load_queues();
    run_program();
    for (int k = 0; k < 8; k++) begin
        base = 100 + 5 * k;
        check_mem(base, a[k] + b[k]);
        check_mem(base + 1, a[k] - b[k]);
        check_mem(base + 2, a[k] & b[k]);
        check_mem(base + 3, a[k] | b[k]);
        check_mem(base + 4, signed_less(a[k], b[k]));
    end
    end_test("random_operands");
endtask

/* verif/cpu_tb.sv */
/*
 * Testbench for the multi-cycle processor. Each test resets the DUT, loads a
 * program and data, runs to end_signal and checks data memory through the peek port.
 */
`timescale 1ns/1ns

module cpu_tb;
    import cpu_pkg::*;

    localparam int CLK_PERIOD   = 10;
    localparam int RESET_CYCLES = 10;
    localparam int NUM_TESTS    = 6;
    // Cycles allowed for one whole test, from reset through the last peek
    localparam int TEST_BUDGET  = 2000;
    // Cycles allowed between start_signal and end_signal
    localparam int RUN_BUDGET   = 1000;

    logic      clk;
    logic      rst_n;
    logic      start_signal;
    logic      load_valid;
    logic      add_into;
    word_t     new_word;
    mem_addr_t peek_addr;
    logic      end_signal;
    word_t     peek_data;

    // Program and data words collected by the running test before loading
    word_t  prog_q[$];
    word_t  data_q[$];
    int     errors;
    int     errors_at_test_start;
    int     tests_passed;
    int     tests_failed;
    integer seed;

    cpu_top i_cpu_top (
        .clk          (clk),
        .rst_n        (rst_n),
        .start_signal (start_signal),
        .load_valid   (load_valid),
        .add_into     (add_into),
        .new_word     (new_word),
        .peek_addr    (peek_addr),
        .end_signal   (end_signal),
        .peek_data    (peek_data)
    );

    always #(CLK_PERIOD / 2) clk = ~clk;

    task automatic check(input string name, input word_t expected, input word_t actual);
        if (actual !== expected) begin
            $display("CHECK FAILED at %0t ns: %s expected %h, got %h",
                     $time, name, expected, actual);
            errors++;
        end
    endtask

    // Reset also returns every loader input to idle
    task automatic apply_reset();
        @(posedge clk);
        rst_n        <= 1'b0;
        start_signal <= 1'b0;
        load_valid   <= 1'b0;
        add_into     <= 1'b0;
        new_word     <= '0;
        repeat (RESET_CYCLES) @(posedge clk);
        rst_n <= 1'b1;
    endtask

    // One word per edge, program words first, then data words
    task automatic load_queues();
        foreach (prog_q[i]) begin
            @(posedge clk);
            load_valid <= 1'b1;
            add_into   <= 1'b0;
            new_word   <= prog_q[i];
        end
        foreach (data_q[i]) begin
            @(posedge clk);
            load_valid <= 1'b1;
            add_into   <= 1'b1;
            new_word   <= data_q[i];
        end
        @(posedge clk);
        load_valid <= 1'b0;
        add_into   <= 1'b0;
    endtask

    task automatic run_program();
        int cycles;
        cycles = 0;
        @(posedge clk);
        start_signal <= 1'b1;
        @(negedge clk);
        while (!end_signal && cycles < RUN_BUDGET) begin
            @(negedge clk);
            cycles++;
        end
        if (!end_signal) begin
            $display("ERROR at %0t ns: end_signal did not rise within %0d cycles of start",
                     $time, RUN_BUDGET);
            errors++;
        end
    endtask

    // peek_data is combinational, so it is settled by the falling edge
    task automatic check_mem(input int addr, input word_t expected);
        word_t data;
        @(posedge clk);
        peek_addr <= mem_addr_t'(addr);
        @(negedge clk);
        data = peek_data;
        check($sformatf("peek_data[%0d]", addr), expected, data);
    endtask

    task automatic begin_test();
        errors_at_test_start = errors;
        prog_q.delete();
        data_q.delete();
        apply_reset();
    endtask

    task automatic end_test(input string name);
        if (errors == errors_at_test_start) begin
            tests_passed++;
            $display("%-22s passed", name);
        end else begin
            tests_failed++;
            $display("%-22s failed with %0d errors", name, errors - errors_at_test_start);
        end
    endtask

    `include "cpu_tests.svh"

    // Whole-run limit in case a test stalls outside run_program
    initial begin
        #(NUM_TESTS * TEST_BUDGET * CLK_PERIOD);
        $display("ERROR: watchdog expired after %0d cycles, the tests did not finish",
                 NUM_TESTS * TEST_BUDGET);
        $display("Something failed");
        $finish;
    end

    initial begin
        clk          = 1'b0;
        rst_n        = 1'b0;
        start_signal = 1'b0;
        load_valid   = 1'b0;
        add_into     = 1'b0;
        new_word     = '0;
        peek_addr    = '0;
        errors       = 0;
        tests_passed = 0;
        tests_failed = 0;
        seed         = 32'hfe79;
        test_load_and_peek();
        test_alu_ops();
        test_load_store_zero();
        test_branch_jump();
        test_signed_compare();
        test_random_operands();
        $display("Summary: %0d tests passed, %0d tests failed, %0d errors",
                 tests_passed, tests_failed, errors);
        if (tests_failed == 0 && errors == 0) begin
            $display("Everything OK");
        end else begin
            $display("Something failed");
        end
        $finish;
    end

endmodule

/* sim.f */
+incdir+verif
rtl/cpu_pkg.sv
rtl/mem_if.sv
rtl/regfile_if.sv
rtl/instr_mem.sv
rtl/data_mem.sv
rtl/reg_file.sv
rtl/alu.sv
rtl/cpu_control.sv
rtl/cpu_top.sv
verif/cpu_tb.sv

/* Makefile */
# Verilator build and run of the processor testbench

LOG := sim.log

.PHONY: help test clean

help:
	@echo "Targets:"
	@echo "  test   build with Verilator, run the testbench and check $(LOG)"
	@echo "  clean  remove the build directory and $(LOG)"
	@echo "  help   show this list"

test:
	verilator --binary --assert -Wno-fatal --top-module cpu_tb -f sim.f \
		--Mdir obj_dir -o cpu_tb_sim
	./obj_dir/cpu_tb_sim | tee $(LOG)
	grep -q "Everything OK" $(LOG)

clean:
	rm -rf obj_dir $(LOG)
